//--- bench/tb_esp_link.sv
`timescale 1ns/1ps

module tb_esp_link;

  // 32 bytes at 150 clk each doubled plus reset and bus probes
  localparam int timeout_cycles = 2 * 32 * 150 + 200;

  logic                   clk;
  logic                   reset;
  logic                   sck;
  logic                   cs_n;
  logic                   mosi;
  esp_link_pkg::cpu_bus_t bus;
  logic                   miso;
  logic                   key_pressed;
  logic                   reset_key;
  logic                   bp_hit;
  logic [2:0]             bp_index;

  integer seed = 32'h3c69df57;
  int     error_count = 0;
  int     cycle_count = 0;

  esp_link_top #(.num_breakpoints(8)) u_dut (
    .clk(clk), .reset(reset), .sck(sck), .cs_n(cs_n), .mosi(mosi), .bus(bus),
    .miso(miso), .key_pressed(key_pressed), .reset_key(reset_key),
    .bp_hit(bp_hit), .bp_index(bp_index)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
      $display("tests failed");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  task automatic expect_equal(input string name, input logic [15:0] exp,
                              input logic [15:0] got);
    assert (got === exp) else begin
      error_count++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // one spi byte in mode 0 msb first with miso taken at each sck rise
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    cs_n = 1'b0;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];             // changes only while sck low
      repeat (8) @(negedge clk);
      sck   = 1'b1;
      rx[i] = miso;
      repeat (8) @(negedge clk);
      sck   = 1'b0;
    end
    repeat (6) @(negedge clk);  // let the last fall through the sync chain
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (16) @(negedge clk);
  endtask

  task automatic send_cmd(input logic [7:0] op, input int n,
                          input logic [7:0] p0, input logic [7:0] p1, input logic [7:0] p2);
    logic [7:0] unused;
    spi_xfer(op, unused);
    if (n > 0) spi_xfer(p0, unused);
    if (n > 1) spi_xfer(p1, unused);
    if (n > 2) spi_xfer(p2, unused);
  endtask

  // opcode then a dummy byte that clocks the answer out
  task automatic query_byte(input logic [7:0] op, output logic [7:0] answer);
    logic [7:0] unused;
    spi_xfer(op, unused);
    spi_xfer(8'h00, answer);   // 00 would be get_cookie if not dropped
  endtask

  // filler byte with an unknown opcode reads 00 when no response is pending
  task automatic check_no_pending_response;
    logic [7:0] answer;
    spi_xfer(8'h99, answer);   // dropped by the framer
    expect_equal("miso", 16'h0000, 16'(answer));
  endtask

  // drive the bus and check the registered match one cycle later
  task automatic probe_breakpoint(input logic [15:0] addr, input logic rd,
                                  input logic exp_hit, input logic [2:0] exp_idx);
    bus.addr = addr;
    bus.rd   = rd;
    @(negedge clk);
    expect_equal("bp_hit", 16'(exp_hit), 16'(bp_hit));
    expect_equal("bp_index", 16'(exp_idx), 16'(bp_index));
    bus.rd = 1'b0;
  endtask

  task automatic check_reset_state;
    expect_equal("miso", 16'h0, 16'(miso));
    expect_equal("bp_hit", 16'h0, 16'(bp_hit));
    expect_equal("bp_index", 16'h0, 16'(bp_index));
    expect_equal("key_pressed", 16'h0, 16'(key_pressed));
    expect_equal("reset_key", 16'h0, 16'(reset_key));
  endtask

  task automatic read_cookie_and_version;
    logic [7:0] answer;
    query_byte(esp_link_pkg::get_cookie, answer);
    expect_equal("cookie", 16'h00af, 16'(answer));
    query_byte(esp_link_pkg::get_version, answer);
    expect_equal("version", 16'h0003, 16'(answer));  // major 0 and minor 3
    // a dummy taken as get_cookie would leave af waiting on miso
    check_no_pending_response();
  endtask

  task automatic read_address_bus;
    logic [7:0]  answer;
    logic [15:0] addr;
    addr     = 16'($random(seed));
    bus.addr = addr;
    query_byte(esp_link_pkg::abus_read, answer);
    expect_equal("abus_read", 16'(addr[7:0]), 16'(answer));
  endtask

  task automatic drive_keyboard_rows;
    logic [2:0] row;
    logic [7:0] val;
    row = 3'($unsigned($random(seed)) % 7);  // rows 0..6
    val = 8'($random(seed));
    if (val == 8'h00) val = 8'h81;
    send_cmd(esp_link_pkg::send_keyb, 2, 8'(row), val, 8'h00);
    expect_equal("key_pressed", 16'h1, 16'(key_pressed));
    expect_equal("reset_key", 16'h0, 16'(reset_key));
    send_cmd(esp_link_pkg::send_keyb, 2, 8'(row), 8'h00, 8'h00);
    expect_equal("key_pressed", 16'h0, 16'(key_pressed));
    send_cmd(esp_link_pkg::send_keyb, 2, 8'd7, 8'h02, 8'h00);  // reset key sits at row 7 bit 1
    expect_equal("reset_key", 16'h1, 16'(reset_key));
  endtask

  task automatic match_breakpoints;
    logic [15:0] a2;
    logic [15:0] a5;
    a2 = 16'($random(seed));
    a5 = 16'($random(seed));
    if (a5 == a2) a5 = ~a2;
    send_cmd(esp_link_pkg::set_breakpoint, 3, 8'd2, a2[7:0], a2[15:8]);
    send_cmd(esp_link_pkg::set_breakpoint, 3, 8'd5, a5[7:0], a5[15:8]);
    send_cmd(esp_link_pkg::enable_breakpoints, 0, 8'h00, 8'h00, 8'h00);
    probe_breakpoint(a5, 1'b1, 1'b1, 3'd5);
    probe_breakpoint(a5, 1'b0, 1'b0, 3'd0);  // no read strobe
    probe_breakpoint(a2, 1'b1, 1'b1, 3'd2);
    send_cmd(esp_link_pkg::disable_breakpoints, 0, 8'h00, 8'h00, 8'h00);
    probe_breakpoint(a5, 1'b1, 1'b0, 3'd0);
    send_cmd(esp_link_pkg::enable_breakpoints, 0, 8'h00, 8'h00, 8'h00);
    send_cmd(esp_link_pkg::clear_breakpoint, 1, 8'd5, 8'h00, 8'h00);
    probe_breakpoint(a5, 1'b1, 1'b0, 3'd0);  // slot 5 gone
    probe_breakpoint(a2, 1'b1, 1'b1, 3'd2);
  endtask

  task automatic skip_unknown_opcode;
    logic [7:0] answer;
    logic [7:0] unused;
    spi_xfer(8'h99, unused);
    query_byte(esp_link_pkg::get_cookie, answer);
    expect_equal("cookie", 16'h00af, 16'(answer));
  endtask

  initial begin
    reset = 1'b1;
    sck   = 1'b0;
    cs_n  = 1'b1;
    mosi  = 1'b0;
    bus   = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_reset_state();
    read_cookie_and_version();
    read_address_bus();
    drive_keyboard_rows();
    match_breakpoints();
    skip_unknown_opcode();
    if (error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- build.f
common/esp_link_pkg.sv
spi_link/spi_byte_receiver.sv
spi_link/spi_response_shifter.sv
hw/cmd_framer.sv
hw/cmd_executor.sv
hw/breakpoint_unit.sv
hw/esp_link_top.sv
bench/tb_esp_link.sv

//--- common/esp_link_pkg.sv
package esp_link_pkg;

  // command opcodes understood by the link, values match the microcontroller firmware
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    get_version         = 8'd15,
    abus_read           = 8'd18,
    send_keyb           = 8'd19
  } cmd_op_e;

  // framer states
  typedef enum logic {
    idle,
    read_params
  } frame_state_e;

  // synchronized spi events
  typedef struct packed {
    logic sck_rise;
    logic sck_fall;
    logic cs_active;   // cs_n low, after sync
  } spi_sync_t;

  // one complete command with its parameter bytes
  typedef struct packed {
    logic       valid;
    cmd_op_e    op;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
  } cmd_t;

  // response byte for the miso shifter
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } resp_t;

  // cpu address bus as seen by the fpga
  typedef struct packed {
    logic [15:0] addr;
    logic        rd;      // read strobe, active high
  } cpu_bus_t;

  localparam logic [7:0] COOKIE        = 8'haf;  // link presence check
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

endpackage

//--- hw/breakpoint_unit.sv
`timescale 1ns/1ps

module breakpoint_unit #(
  parameter int num_breakpoints = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  esp_link_pkg::cmd_t     cmd,
  input  esp_link_pkg::cpu_bus_t bus,
  output logic                   bp_hit,
  output logic [2:0]             bp_index
);

  localparam int idx_w = $clog2(num_breakpoints);

  logic [15:0]                slot_addr [num_breakpoints];
  logic [num_breakpoints-1:0] slot_active;
  logic                       bp_enabled;   // global flag
  logic [idx_w-1:0]           slot_sel;
  logic                       match_any;
  logic [2:0]                 match_idx;
  logic                       hit_now;

  assign slot_sel = cmd.p0[idx_w-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_active <= '0;
      bp_enabled  <= 1'b0;
    end else if (cmd.valid) begin
      case (cmd.op)
        esp_link_pkg::set_breakpoint:      slot_active[slot_sel] <= 1'b1;
        esp_link_pkg::clear_breakpoint:    slot_active[slot_sel] <= 1'b0;
        esp_link_pkg::enable_breakpoints:  bp_enabled <= 1'b1;
        esp_link_pkg::disable_breakpoints: bp_enabled <= 1'b0;
        default: ;
      endcase
    end
  end

  // address is p2:p1
  always_ff @(posedge clk) begin
    if (cmd.valid && cmd.op == esp_link_pkg::set_breakpoint)
      slot_addr[slot_sel] <= {cmd.p2, cmd.p1};
  end

  // walk down so the lowest slot ends up in match_idx
  always_comb begin
    match_any = 1'b0;
    match_idx = 3'd0;
    for (int i = num_breakpoints - 1; i >= 0; i--) begin
      if (slot_active[i] && slot_addr[i] == bus.addr) begin
        match_any = 1'b1;
        match_idx = 3'(i);
      end
    end
  end

  assign hit_now = bp_enabled && bus.rd && match_any;

  always_ff @(posedge clk) begin
    if (reset) begin
      bp_hit   <= 1'b0;
      bp_index <= 3'd0;
    end else begin
      bp_hit   <= hit_now;
      bp_index <= hit_now ? match_idx : 3'd0;
    end
  end

endmodule

//--- hw/cmd_executor.sv
`timescale 1ns/1ps

module cmd_executor (
  input  logic                   clk,
  input  logic                   reset,
  input  esp_link_pkg::cmd_t     cmd,
  input  esp_link_pkg::cpu_bus_t bus,
  output esp_link_pkg::resp_t    resp,
  output logic                   key_pressed,
  output logic                   reset_key
);

  logic [7:0] matrix [8];   // keyboard rows as sent by the microcontroller
  logic [7:0] rows_or;

  // any key in any row
  always_comb begin
    rows_or = 8'd0;
    for (int r = 0; r < 8; r++)
      rows_or = rows_or | matrix[r];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp.valid  <= 1'b0;
      key_pressed <= 1'b0;
      reset_key   <= 1'b0;
      for (int r = 0; r < 8; r++)
        matrix[r] <= 8'd0;
    end else begin
      resp.valid  <= 1'b0;
      key_pressed <= |rows_or;
      reset_key   <= matrix[7][1];   // reset key lives in row 7
      if (cmd.valid) begin
        case (cmd.op)
          esp_link_pkg::get_cookie: begin
            resp.valid <= 1'b1;
            resp.data  <= esp_link_pkg::COOKIE;
          end
          esp_link_pkg::get_version: begin
            resp.valid <= 1'b1;
            resp.data  <= {esp_link_pkg::VERSION_MAJOR, esp_link_pkg::VERSION_MINOR};
          end
          esp_link_pkg::abus_read: begin
            resp.valid <= 1'b1;
            resp.data  <= bus.addr[7:0];  // sampled at command time
          end
          esp_link_pkg::send_keyb:
            matrix[cmd.p0[2:0]] <= cmd.p1;
          default: ;   // breakpoint ops handled elsewhere
        endcase
      end
    end
  end

endmodule

//--- hw/cmd_framer.sv
`timescale 1ns/1ps

module cmd_framer (
  input  logic               clk,
  input  logic               reset,
  input  logic               rx_valid,
  input  logic [7:0]         rx_byte,
  output esp_link_pkg::cmd_t cmd
);

  esp_link_pkg::frame_state_e state;
  logic [1:0] remaining;     // parameter bytes still due
  logic [1:0] idx;           // next parameter slot
  logic [1:0] param_count;
  logic       known_op;

  // parameter count per opcode
  always_comb begin
    known_op    = 1'b1;
    param_count = 2'd0;
    case (rx_byte)
      esp_link_pkg::set_breakpoint:   param_count = 2'd3;  // slot, addr lo, addr hi
      esp_link_pkg::send_keyb:        param_count = 2'd2;  // row, value
      esp_link_pkg::clear_breakpoint: param_count = 2'd1;
      esp_link_pkg::get_cookie,
      esp_link_pkg::get_version,
      esp_link_pkg::abus_read,
      esp_link_pkg::enable_breakpoints,
      esp_link_pkg::disable_breakpoints:
        param_count = 2'd0;
      default: known_op = 1'b0;  // dropped, framer stays idle
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= esp_link_pkg::idle;
      remaining <= 2'd0;
      idx       <= 2'd0;
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= 1'b0;  // single cycle strobe
      if (rx_valid) begin
        case (state)
          esp_link_pkg::idle: begin
            if (known_op) begin
              cmd.op <= esp_link_pkg::cmd_op_e'(rx_byte);
              idx    <= 2'd0;
              if (param_count == 2'd0)
                cmd.valid <= 1'b1;   // opcode alone is the whole command
              else begin
                remaining <= param_count;
                state     <= esp_link_pkg::read_params;
              end
            end
          end
          esp_link_pkg::read_params: begin
            case (idx)
              2'd0:    cmd.p0 <= rx_byte;
              2'd1:    cmd.p1 <= rx_byte;
              default: cmd.p2 <= rx_byte;
            endcase
            idx       <= idx + 2'd1;
            remaining <= remaining - 2'd1;
            if (remaining == 2'd1) begin
              cmd.valid <= 1'b1;   // last parameter in
              state     <= esp_link_pkg::idle;
            end
          end
        endcase
      end
    end
  end

endmodule

//--- hw/esp_link_top.sv
`timescale 1ns/1ps

module esp_link_top #(
  parameter int num_breakpoints = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   mosi,
  input  esp_link_pkg::cpu_bus_t bus,
  output logic                   miso,
  output logic                   key_pressed,
  output logic                   reset_key,
  output logic                   bp_hit,
  output logic [2:0]             bp_index
);

  esp_link_pkg::spi_sync_t sync;
  esp_link_pkg::cmd_t      cmd;
  esp_link_pkg::resp_t     resp;
  logic                    rx_valid;
  logic [7:0]              rx_byte;
  logic                    tx_busy;   // response going out, ignore incoming bytes

  spi_byte_receiver u_rx (
    .clk(clk), .reset(reset), .sck(sck), .cs_n(cs_n), .mosi(mosi),
    .tx_busy(tx_busy), .sync(sync), .rx_valid(rx_valid), .rx_byte(rx_byte)
  );

  cmd_framer u_framer (
    .clk(clk), .reset(reset), .rx_valid(rx_valid), .rx_byte(rx_byte), .cmd(cmd)
  );

  cmd_executor u_exec (
    .clk(clk), .reset(reset), .cmd(cmd), .bus(bus), .resp(resp),
    .key_pressed(key_pressed), .reset_key(reset_key)
  );

  // branches off the framer output
  breakpoint_unit #(.num_breakpoints(num_breakpoints)) u_bp (
    .clk(clk), .reset(reset), .cmd(cmd), .bus(bus),
    .bp_hit(bp_hit), .bp_index(bp_index)
  );

  spi_response_shifter u_tx (
    .clk(clk), .reset(reset), .sync(sync), .resp(resp),
    .miso(miso), .tx_busy(tx_busy)
  );

endmodule

//--- spi_link/spi_byte_receiver.sv
`timescale 1ns/1ps

module spi_byte_receiver (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sck,
  input  logic                    cs_n,
  input  logic                    mosi,
  input  logic                    tx_busy,
  output esp_link_pkg::spi_sync_t sync,
  output logic                    rx_valid,
  output logic [7:0]              rx_byte
);

  logic [2:0] sck_r;    // two sync stages plus edge stage
  logic [2:0] cs_r;
  logic [1:0] mosi_r;
  logic [2:0] bit_cnt;
  logic [7:0] shift_q;

  // sync chains, cs held inactive in reset
  always_ff @(posedge clk) begin
    if (reset) begin
      sck_r  <= '0;
      cs_r   <= '1;
      mosi_r <= '0;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_n};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  assign sync.sck_rise  = (sck_r[2:1] == 2'b01);
  assign sync.sck_fall  = (sck_r[2:1] == 2'b10);
  assign sync.cs_active = ~cs_r[2];

  // bit count, byte strobe on wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      // bytes clocked during a response are dummies
      rx_valid <= sync.cs_active && sync.sck_rise && (bit_cnt == 3'd7) && !tx_busy;
      if (!sync.cs_active)
        bit_cnt <= 3'd0;
      else if (sync.sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  // msb first
  always_ff @(posedge clk) begin
    if (sync.cs_active && sync.sck_rise)
      shift_q <= {shift_q[6:0], mosi_r[1]};
  end

  assign rx_byte = shift_q;  // complete when rx_valid is high

endmodule

//--- spi_link/spi_response_shifter.sv
`timescale 1ns/1ps

module spi_response_shifter (
  input  logic                    clk,
  input  logic                    reset,
  input  esp_link_pkg::spi_sync_t sync,
  input  esp_link_pkg::resp_t     resp,
  output logic                    miso,
  output logic                    tx_busy
);

  logic [7:0] shift_q;
  logic [2:0] shift_cnt;   // bits already shifted out
  logic       sampled;     // master took current bit on a rising edge

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q   <= 8'd0;
      shift_cnt <= 3'd0;
      sampled   <= 1'b0;
      tx_busy   <= 1'b0;
    end else if (resp.valid) begin
      // new byte wins, bit 7 on miso right away
      shift_q   <= resp.data;
      shift_cnt <= 3'd0;
      sampled   <= 1'b0;
      tx_busy   <= 1'b1;
    end else if (tx_busy && sync.cs_active) begin
      if (sync.sck_rise)
        sampled <= 1'b1;
      else if (sync.sck_fall && sampled) begin
        // trailing fall of the command byte is skipped by the sampled flag
        shift_q   <= {shift_q[6:0], 1'b0};
        shift_cnt <= shift_cnt + 3'd1;
        sampled   <= 1'b0;
        if (shift_cnt == 3'd7)
          tx_busy <= 1'b0;   // eighth bit gone
      end
    end
  end

  assign miso = sync.cs_active & shift_q[7];  // low while deselected

endmodule
